//--- project.f
source/frontend_pkg.sv
source/fetch_pc_gen.sv
source/fetch_queue.sv
source/group_dispatch.sv
source/frontend_top.sv
sim/frontend_checker.sv
sim/frontend_tb.sv

//--- Bender.yml
package:
  name: frontend

sources:
  # package first, then the blocks, top level last
  - files:
      - source/frontend_pkg.sv
      - source/fetch_pc_gen.sv
      - source/fetch_queue.sv
      - source/group_dispatch.sv
      - source/frontend_top.sv

  # testbench and checker, simulation only
  - target: simulation
    files:
      - sim/frontend_checker.sv
      - sim/frontend_tb.sv

//--- sim/frontend_tb.sv
`timescale 1ns/1ns
`default_nettype none

module frontend_tb import frontend_pkg::*; ();

    localparam int FQ_DEPTH     = 4;
    localparam int ROB_DEPTH    = 32;
    localparam int RESET_CYCLES = 4;
    localparam int MIN_GROUPS   = 200;
    localparam int MAX_CYCLES   = 20000;   // bound on the stimulus loop
    localparam logic [31:0] SEED = 32'h14dc_1676;

    logic                   aclk;
    logic                   rst_n;
    logic                   redirect_valid;
    addr_t                  redirect_pc;
    logic                   dispatch_ready;
    logic                   dispatch_valid;
    slot_mask_t             dispatch_mask;
    slot_info_t [SLOTS-1:0] dispatch_slots;
    logic                   chk_err;
    int                     taken_cnt;
    logic [5:0]             hits;
    int                     stall_left;   // cycles left in a forced stall burst

    frontend_top #(
        .FQ_DEPTH  (FQ_DEPTH),
        .ROB_DEPTH (ROB_DEPTH)
    ) dut0 (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .dispatch_ready (dispatch_ready),
        .dispatch_valid (dispatch_valid),
        .dispatch_mask  (dispatch_mask),
        .dispatch_slots (dispatch_slots)
    );

    frontend_checker #(
        .FQ_DEPTH  (FQ_DEPTH),
        .ROB_DEPTH (ROB_DEPTH)
    ) checker0 (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .dispatch_ready (dispatch_ready),
        .dispatch_valid (dispatch_valid),
        .dispatch_mask  (dispatch_mask),
        .dispatch_slots (dispatch_slots),
        .err            (chk_err),
        .taken_cnt      (taken_cnt),
        .hits           (hits)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    task automatic stop_on_failure(input string why);
        $display("*** FAILED ***");
        $fatal(1, "%s", why);
    endtask

    function automatic logic goals_met();
        return (taken_cnt >= MIN_GROUPS) && (&hits);
    endfunction

    // one cycle of redirects and back-pressure
    task automatic drive_inputs();
        if (redirect_valid) begin
            redirect_valid <= 1'b0;   // one-cycle strobe
        end else if ($urandom_range(39) == 0) begin
            redirect_valid <= 1'b1;
            redirect_pc    <= RESET_PC | ($urandom & 32'h000F_FFFC);
        end
        if (stall_left > 0) begin
            dispatch_ready <= 1'b0;
            stall_left = stall_left - 1;
        end else if ($urandom_range(49) == 0) begin
            // long enough to fill the queue
            stall_left = FQ_DEPTH + 2;
            dispatch_ready <= 1'b0;
        end else begin
            dispatch_ready <= ($urandom_range(99) < 70);
        end
    endtask

    always @(posedge chk_err) begin
        stop_on_failure("checker assertion failed, see mismatch line above");
    end

    initial begin
        int cycles;
        void'($urandom(SEED));
        rst_n          = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = RESET_PC;
        dispatch_ready = 1'b0;
        stall_left     = 0;
        cycles         = 0;
        repeat (RESET_CYCLES) @(posedge aclk);
        rst_n <= 1'b1;
        while (!goals_met() && cycles < MAX_CYCLES) begin
            @(posedge aclk);
            drive_inputs();
            cycles++;
        end
        if (goals_met()) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            stop_on_failure($sformatf("timeout after %0d cycles, %0d groups taken, hits %b",
                                      cycles, taken_cnt, hits));
        end
    end

endmodule

`default_nettype wire

//--- sim/frontend_checker.sv
`timescale 1ns/1ns
`default_nettype none

module frontend_checker import frontend_pkg::*; #(
    parameter int FQ_DEPTH  = 4,
    parameter int ROB_DEPTH = 32
) (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  logic                   redirect_valid,
    input  addr_t                  redirect_pc,
    input  logic                   dispatch_ready,
    input  logic                   dispatch_valid,
    input  slot_mask_t             dispatch_mask,
    input  slot_info_t [SLOTS-1:0] dispatch_slots,
    output logic                   err,         // goes high on the first failed check
    output int                     taken_cnt,
    output logic [5:0]             hits         // behaviours reached, bit per case below
);

    localparam int VW = $bits(slot_info_t) * SLOTS;

    addr_t      exp_pc;        // block_pc of the next group to be taken
    slot_mask_t exp_mask;
    int         exp_rob;       // next free rob index
    rob_idx_t   exp_idx [SLOTS];
    logic       take;
    logic       redir_seen;
    logic       after_redir;   // redirected group not yet taken
    int         stall_run;

    initial err = 1'b0;

    task automatic report_mismatch(input string name, input logic [VW-1:0] exp_val,
                                   input logic [VW-1:0] act_val);
        $display("mismatch at time %0t: %s expected %0h actual %0h",
                 $time, name, exp_val, act_val);
        err = 1'b1;
    endtask

    // slots from the word position of pc up to the end of the block
    function automatic slot_mask_t entry_mask(input addr_t pc);
        int         first;
        slot_mask_t m;
        first = int'(pc % BLOCK_BYTES) / INSTR_BYTES;
        m = '0;
        for (int i = first; i < SLOTS; i++) begin
            m[i] = 1'b1;
        end
        return m;
    endfunction

    assign take = dispatch_valid && dispatch_ready;

    // valid slots numbered in order from the running counter
    always_comb begin
        int n;
        n = exp_rob;
        for (int i = 0; i < SLOTS; i++) begin
            exp_idx[i] = rob_idx_t'(n % ROB_DEPTH);
            if (exp_mask[i]) begin
                n = n + 1;
            end
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            exp_pc   <= RESET_PC;
            exp_mask <= '1;
            exp_rob  <= 0;
        end else begin
            if (take) begin   // group taken here belongs to the old sequence
                exp_pc   <= exp_pc + addr_t'(BLOCK_BYTES);
                exp_mask <= '1;
                exp_rob  <= (exp_rob + $countones(exp_mask)) % ROB_DEPTH;
            end
            if (redirect_valid) begin
                exp_pc   <= redirect_pc & ~addr_t'(BLOCK_BYTES - 1);
                exp_mask <= entry_mask(redirect_pc);
            end
        end
    end

    // 0 first group, 1 redirected group, 2 partial mask, 3 take on redirect,
    // 4 held output, 5 stall longer than the queue
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            taken_cnt   <= 0;
            hits        <= '0;
            redir_seen  <= 1'b0;
            after_redir <= 1'b0;
            stall_run   <= 0;
        end else begin
            if (take) begin
                taken_cnt <= taken_cnt + 1;
            end
            if (take && taken_cnt == 0 && !redir_seen) hits[0] <= 1'b1;
            if (take && after_redir) hits[1] <= 1'b1;
            if (take && exp_mask != '1) hits[2] <= 1'b1;
            if (take && redirect_valid) hits[3] <= 1'b1;
            if (dispatch_valid && !dispatch_ready && !redirect_valid) hits[4] <= 1'b1;
            if (!dispatch_ready && !redirect_valid && stall_run >= FQ_DEPTH) hits[5] <= 1'b1;
            if (redirect_valid) begin
                redir_seen  <= 1'b1;
                after_redir <= 1'b1;
            end else if (take) begin
                after_redir <= 1'b0;
            end
            stall_run <= (!dispatch_ready && !redirect_valid) ? stall_run + 1 : 0;
        end
    end

    a_mask: assert property (@(posedge aclk) disable iff (!rst_n)
        take |-> dispatch_mask == exp_mask)
        else report_mismatch("dispatch_mask", $sampled(exp_mask), $sampled(dispatch_mask));

    for (genvar s = 0; s < SLOTS; s++) begin : g_slot
        a_pc: assert property (@(posedge aclk) disable iff (!rst_n)
            take |-> dispatch_slots[s].pc == exp_pc + addr_t'(INSTR_BYTES * s))
            else report_mismatch($sformatf("dispatch_slots[%0d].pc", s),
                                 $sampled(exp_pc) + addr_t'(INSTR_BYTES * s),
                                 $sampled(dispatch_slots[s].pc));

        a_next_pc: assert property (@(posedge aclk) disable iff (!rst_n)
            take |-> dispatch_slots[s].pred_next_pc == exp_pc + addr_t'(INSTR_BYTES * (s + 1)))
            else report_mismatch($sformatf("dispatch_slots[%0d].pred_next_pc", s),
                                 $sampled(exp_pc) + addr_t'(INSTR_BYTES * (s + 1)),
                                 $sampled(dispatch_slots[s].pred_next_pc));

        // an empty slot expects the index of the next valid one
        a_rob_idx: assert property (@(posedge aclk) disable iff (!rst_n)
            take |-> dispatch_slots[s].rob_idx == exp_idx[s])
            else report_mismatch($sformatf("dispatch_slots[%0d].rob_idx", s),
                                 $sampled(exp_idx[s]), $sampled(dispatch_slots[s].rob_idx));
    end

    // queue is flushed so nothing shows right after a redirect
    a_redir_gap: assert property (@(posedge aclk) disable iff (!rst_n)
        redirect_valid |=> !dispatch_valid)
        else report_mismatch("dispatch_valid", 1'b0, $sampled(dispatch_valid));

    a_hold_mask: assert property (@(posedge aclk) disable iff (!rst_n)
        (dispatch_valid && !dispatch_ready && !redirect_valid)
            |=> dispatch_valid && dispatch_mask == $past(dispatch_mask))
        else report_mismatch("dispatch_mask", $past(dispatch_mask), $sampled(dispatch_mask));

    a_hold_slots: assert property (@(posedge aclk) disable iff (!rst_n)
        (dispatch_valid && !dispatch_ready && !redirect_valid)
            |=> dispatch_slots == $past(dispatch_slots))
        else report_mismatch("dispatch_slots", $past(dispatch_slots), $sampled(dispatch_slots));

endmodule

`default_nettype wire

//--- source/frontend_top.sv
`timescale 1ns/1ns
`default_nettype none

module frontend_top import frontend_pkg::*; #(
    parameter int FQ_DEPTH  = 4,
    parameter int ROB_DEPTH = 32
) (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  logic                   redirect_valid,
    input  addr_t                  redirect_pc,
    input  logic                   dispatch_ready,
    output logic                   dispatch_valid,
    output slot_mask_t             dispatch_mask,
    output slot_info_t [SLOTS-1:0] dispatch_slots
);

    fetch_group_t fg;          // pc generator to queue
    logic         fg_valid;
    logic         fq_ready;
    fetch_group_t head;        // queue head to dispatch
    logic         head_valid;
    logic         pop;

    fetch_pc_gen pc_gen0 (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fq_ready       (fq_ready),
        .fg             (fg),
        .fg_valid       (fg_valid)
    );

    // redirect also empties the queue
    fetch_queue #(
        .FQ_DEPTH (FQ_DEPTH)
    ) fq0 (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .flush      (redirect_valid),
        .fg         (fg),
        .fg_valid   (fg_valid),
        .fq_ready   (fq_ready),
        .head       (head),
        .head_valid (head_valid),
        .pop        (pop)
    );

    group_dispatch #(
        .ROB_DEPTH (ROB_DEPTH)
    ) disp0 (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .head           (head),
        .head_valid     (head_valid),
        .pop            (pop),
        .dispatch_ready (dispatch_ready),
        .dispatch_valid (dispatch_valid),
        .dispatch_mask  (dispatch_mask),
        .dispatch_slots (dispatch_slots)
    );

endmodule

`default_nettype wire

//--- source/group_dispatch.sv
`timescale 1ns/1ns
`default_nettype none

module group_dispatch import frontend_pkg::*; #(
    parameter int ROB_DEPTH = 32
) (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  fetch_group_t           head,
    input  logic                   head_valid,
    output logic                   pop,
    input  logic                   dispatch_ready,
    output logic                   dispatch_valid,
    output slot_mask_t             dispatch_mask,
    output slot_info_t [SLOTS-1:0] dispatch_slots
);

    // index wrap for a power-of-two ROB_DEPTH
    localparam rob_idx_t ROB_MASK = rob_idx_t'(ROB_DEPTH - 1);

    rob_idx_t alloc_cnt;   // next free rob index
    rob_idx_t grp_cnt;     // set bits in the head mask

    assign dispatch_valid = head_valid;
    assign dispatch_mask  = head.slot_mask;
    assign pop            = head_valid && dispatch_ready;   // group taken

    // per-slot pc, sequential next pc and rob index
    always_comb begin
        rob_idx_t offs;
        addr_t    slot_pc;
        offs = '0;
        for (int i = 0; i < SLOTS; i++) begin
            slot_pc = head.block_pc + addr_t'(INSTR_BYTES * i);
            dispatch_slots[i].pc           = slot_pc;
            dispatch_slots[i].pred_next_pc = slot_pc + addr_t'(INSTR_BYTES);   // never taken
            // an empty slot shows the index the next valid slot gets
            dispatch_slots[i].rob_idx      = (alloc_cnt + offs) & ROB_MASK;
            offs = offs + rob_idx_t'(head.slot_mask[i]);
        end
        grp_cnt = offs;
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            alloc_cnt <= '0;
        end else if (pop) begin
            alloc_cnt <= (alloc_cnt + grp_cnt) & ROB_MASK;
        end
    end

    // every group built upstream holds at least one slot
    a_mask_nonzero: assert property (@(posedge aclk) disable iff (!rst_n)
        pop |-> head.slot_mask != '0)
        else $error("group_dispatch: taken group with empty mask");

endmodule

`default_nettype wire

//--- source/fetch_queue.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_queue import frontend_pkg::*; #(
    parameter int FQ_DEPTH = 4
) (
    input  logic         aclk,
    input  logic         rst_n,
    input  logic         flush,
    input  fetch_group_t fg,
    input  logic         fg_valid,
    output logic         fq_ready,
    output fetch_group_t head,
    output logic         head_valid,
    input  logic         pop
);

    localparam int PTR_W = $clog2(FQ_DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   cnt_t;   // one extra bit to tell full from empty

    localparam cnt_t FULL_CNT = cnt_t'(FQ_DEPTH);

    fetch_group_t mem [FQ_DEPTH];
    ptr_t         wr_ptr;
    ptr_t         rd_ptr;
    cnt_t         count;
    logic         push;

    assign fq_ready   = (count != FULL_CNT);
    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];
    assign push       = fg_valid && fq_ready && !flush;   // flush drops a same-cycle push

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= fg;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            // a pop in this cycle is already taken by dispatch
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + ptr_t'(1);   // wraps, depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + ptr_t'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + cnt_t'(1);
                2'b01:   count <= count - cnt_t'(1);
                default: count <= count;          // idle or push with pop
            endcase
        end
    end

    // occupancy stays within the storage
    a_no_overflow: assert property (@(posedge aclk) disable iff (!rst_n)
        count <= FULL_CNT)
        else $error("fetch_queue: occupancy above depth");

    // dispatch only pops a present group
    a_no_underflow: assert property (@(posedge aclk) disable iff (!rst_n)
        pop |-> head_valid)
        else $error("fetch_queue: pop while empty");

    a_head_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        (head_valid && !pop && !flush) |=> (head_valid && head == $past(head)))
        else $error("fetch_queue: head changed without pop or flush");

endmodule

`default_nettype wire

//--- source/fetch_pc_gen.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_pc_gen import frontend_pkg::*; (
    input  logic         aclk,
    input  logic         rst_n,
    input  logic         redirect_valid,
    input  addr_t        redirect_pc,
    input  logic         fq_ready,
    output fetch_group_t fg,
    output logic         fg_valid
);

    localparam int OFS_LO = $clog2(INSTR_BYTES);   // lowest slot-select bit
    localparam int OFS_HI = $clog2(BLOCK_BYTES);   // block offset width
    localparam int ADDR_W = $bits(addr_t);

    addr_t      pc_q;         // may hold an unaligned redirect target
    logic       run_q;        // low for the first cycle out of reset
    addr_t      block_pc;
    slot_idx_t  start_slot;
    slot_mask_t start_mask;
    logic       xfer;

    assign block_pc   = {pc_q[ADDR_W-1:OFS_HI], {OFS_HI{1'b0}}};
    assign start_slot = pc_q[OFS_HI-1:OFS_LO];

    // slots from the entry position up to the end of the block
    always_comb begin
        for (int i = 0; i < SLOTS; i++) begin
            start_mask[i] = (slot_idx_t'(i) >= start_slot);
        end
    end

    assign fg       = '{block_pc: block_pc, slot_mask: start_mask};
    assign fg_valid = run_q && !redirect_valid;   // nothing pushed while redirecting
    assign xfer     = fg_valid && fq_ready;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q  <= RESET_PC;
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (redirect_valid) begin
                pc_q <= redirect_pc;   // word offset kept for the first mask
            end else if (xfer) begin
                // next aligned block, drops any entry offset
                pc_q <= block_pc + addr_t'(BLOCK_BYTES);
            end
        end
    end

    // blocks handed to the queue follow each other by one block
    a_seq_block: assert property (@(posedge aclk) disable iff (!rst_n)
        xfer |=> fg.block_pc == $past(fg.block_pc) + addr_t'(BLOCK_BYTES))
        else $error("fetch_pc_gen: block_pc did not advance by one block");

endmodule

`default_nettype wire

//--- source/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

    // fetch block geometry
    localparam int SLOTS       = 4;                     // instructions per fetch block
    localparam int INSTR_BYTES = 4;
    localparam int BLOCK_BYTES = SLOTS * INSTR_BYTES;   // 16 bytes

    localparam int ROB_IDX_W = 5;   // rob index width, depth up to 32

    typedef logic [31:0]              addr_t;        // byte address
    typedef logic [$clog2(SLOTS)-1:0] slot_idx_t;    // slot position in a block
    typedef logic [SLOTS-1:0]         slot_mask_t;   // one valid bit per slot
    typedef logic [ROB_IDX_W-1:0]     rob_idx_t;

    // first fetch address out of reset
    localparam addr_t RESET_PC = 32'h1C00_0000;

    // one fetch group as it travels from the pc generator through the queue
    typedef struct packed {
        addr_t      block_pc;   // 16-byte aligned base
        slot_mask_t slot_mask;
    } fetch_group_t;

    // per-slot record handed to rename
    typedef struct packed {
        addr_t    pc;
        addr_t    pred_next_pc;   // always pc + 4, no predictor
        rob_idx_t rob_idx;
    } slot_info_t;

endpackage

`default_nettype wire
